// File: kl_pkg.sv
package kl_pkg;

  // One EBUS word. Bit 0 is the most significant bit, as DEC numbers it
  typedef logic [0:35] word_t;

  // Diagnostic function code carried on the DS lines
  typedef logic [0:6] diag_fn_t;

  // Field held by one EDP slice
  typedef logic [0:5] slice_t;

  // What every board presents to the EBUS mux
  typedef struct packed {
    logic  driving;
    word_t data;
  } ebus_driver_t;

  // Registered per-board controls from the function decoder.
  // The write and increment fields are one-cycle pulses taken from the strobe.
  // The read fields are levels that follow the held function code
  typedef struct packed {
    logic scr0_wr;
    logic scr1_wr;
    logic scr0_rd;
    logic scr1_rd;
    logic edp_ld;
    logic edp_rd;
    logic edp_inc;
  } diag_cmd_t;

  // Scratch board functions
  localparam diag_fn_t FN_SCR0_WR = 7'h10;
  localparam diag_fn_t FN_SCR1_WR = 7'h11;
  localparam diag_fn_t FN_SCR0_RD = 7'h12;
  localparam diag_fn_t FN_SCR1_RD = 7'h13;

  // EDP accumulator functions
  localparam diag_fn_t FN_EDP_LD  = 7'h20;
  localparam diag_fn_t FN_EDP_RD  = 7'h21;
  localparam diag_fn_t FN_EDP_INC = 7'h22;

  // The EDP accumulator is built from six slices of six bits.
  // Slice k covers word bits 6k to 6k+5, so slice 5 is the low end
  localparam int EDP_SLICES = 6;
  localparam int SLICE_BITS = 6;

endpackage

// File: diag_ctl.sv
`timescale 1ns/10ps

module diag_ctl (
  input  logic                clk,
  input  logic                arst_n,
  input  kl_pkg::diag_fn_t    ds,
  input  logic                diag_strobe,
  output kl_pkg::diag_cmd_t   cmd
);

  kl_pkg::diag_cmd_t cmd_next;

  // Decode the function code once here so no board has to look at DS
  always_comb begin
    cmd_next = '0;

    // Writes and the increment only happen on a strobe
    if (diag_strobe) begin
      cmd_next.scr0_wr = (ds == kl_pkg::FN_SCR0_WR);
      cmd_next.scr1_wr = (ds == kl_pkg::FN_SCR1_WR);
      cmd_next.edp_ld  = (ds == kl_pkg::FN_EDP_LD);
      cmd_next.edp_inc = (ds == kl_pkg::FN_EDP_INC);
    end

    // Reads hold for as long as the front end keeps the code on DS
    cmd_next.scr0_rd = (ds == kl_pkg::FN_SCR0_RD);
    cmd_next.scr1_rd = (ds == kl_pkg::FN_SCR1_RD);
    cmd_next.edp_rd  = (ds == kl_pkg::FN_EDP_RD);
  end

  // One register stage between the front end and the boards.
  // A strobe sampled on one edge becomes a one-cycle control on the next
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cmd <= '0;
    end else begin
      cmd <= cmd_next;
    end
  end

endmodule

// File: scratch_board.sv
`timescale 1ns/10ps

module scratch_board (
  input  logic                  clk,
  input  logic                  arst_n,
  input  kl_pkg::diag_cmd_t     cmd,
  input  kl_pkg::word_t         ebus_word,
  output kl_pkg::ebus_driver_t  drv
);

  // Two full-word diagnostic registers
  kl_pkg::word_t scr0;
  kl_pkg::word_t scr1;

  // Each register takes the bus word on its own write pulse
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      scr0 <= '0;
      scr1 <= '0;
    end else begin
      if (cmd.scr0_wr) begin
        scr0 <= ebus_word;
      end
      if (cmd.scr1_wr) begin
        scr1 <= ebus_word;
      end
    end
  end

  // Drive the selected register while its read level is up
  always_comb begin
    drv.driving = cmd.scr0_rd | cmd.scr1_rd;
    if (cmd.scr0_rd) begin
      drv.data = scr0;
    end else if (cmd.scr1_rd) begin
      drv.data = scr1;
    end else begin
      drv.data = '0;
    end
  end

endmodule

// File: edp_slice.sv
`timescale 1ns/10ps

module edp_slice #(
  parameter int SLICE = 0
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  kl_pkg::diag_cmd_t     cmd,
  input  kl_pkg::word_t         ebus_word,
  input  logic                  cry_in,
  output logic                  cry_out,
  output kl_pkg::ebus_driver_t  drv
);

  kl_pkg::slice_t             field;
  logic [kl_pkg::SLICE_BITS:0] sum;

  // Field plus incoming carry, one bit wider to catch the carry out
  always_comb begin
    sum = {1'b0, field} + {{kl_pkg::SLICE_BITS{1'b0}}, cry_in};
  end

  // The carry ripples toward bit 0 whether or not an increment is
  // under way; the slice above only uses it on an increment pulse
  assign cry_out = sum[kl_pkg::SLICE_BITS];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      field <= '0;
    end else if (cmd.edp_ld) begin
      // Pick this slice's six bits out of the bus word
      field <= ebus_word[SLICE * kl_pkg::SLICE_BITS +: kl_pkg::SLICE_BITS];
    end else if (cmd.edp_inc) begin
      field <= sum[kl_pkg::SLICE_BITS-1:0];
    end
  end

  // On a read the slice only fills its own bit positions.
  // The mux assembles the full word from all six slices
  always_comb begin
    drv.driving = cmd.edp_rd;
    drv.data    = '0;
    if (cmd.edp_rd) begin
      drv.data[SLICE * kl_pkg::SLICE_BITS +: kl_pkg::SLICE_BITS] = field;
    end
  end

endmodule

// File: ebus_mux.sv
`timescale 1ns/10ps

module ebus_mux (
  input  kl_pkg::ebus_driver_t  fe_drv,
  input  kl_pkg::ebus_driver_t  scr_drv,
  input  kl_pkg::ebus_driver_t  edp_drv [0:kl_pkg::EDP_SLICES-1],
  output kl_pkg::word_t         ebus_word,
  output logic                  ebus_parity
);

  logic edp_any;

  // The EDP group owns the bus when any one of its slices drives
  always_comb begin
    edp_any = 1'b0;
    for (int k = 0; k < kl_pkg::EDP_SLICES; k++) begin
      edp_any = edp_any | edp_drv[k].driving;
    end
  end

  // Priority is front end, then scratch board, then the EDP group.
  // An idle bus reads as zero
  always_comb begin
    ebus_word = '0;
    if (fe_drv.driving) begin
      ebus_word = fe_drv.data;
    end else if (scr_drv.driving) begin
      ebus_word = scr_drv.data;
    end else if (edp_any) begin
      // Each slice supplies only the six bits it owns
      for (int k = 0; k < kl_pkg::EDP_SLICES; k++) begin
        ebus_word[k * kl_pkg::SLICE_BITS +: kl_pkg::SLICE_BITS] =
          edp_drv[k].data[k * kl_pkg::SLICE_BITS +: kl_pkg::SLICE_BITS];
      end
    end
  end

  // Odd parity over word and parity bit together
  assign ebus_parity = ~^ebus_word;

endmodule

// File: kl_ebus_top.sv
`timescale 1ns/10ps

module kl_ebus_top (
  input  logic               clk,
  input  logic               arst_n,
  input  kl_pkg::diag_fn_t   ds,
  input  logic               diag_strobe,
  input  logic               fe_drive,
  input  kl_pkg::word_t      fe_data,
  output kl_pkg::word_t      ebus_data,
  output logic               ebus_parity
);

  kl_pkg::diag_cmd_t     cmd;
  kl_pkg::ebus_driver_t  fe_drv;
  kl_pkg::ebus_driver_t  scr_drv;
  kl_pkg::ebus_driver_t  edp_drv [0:kl_pkg::EDP_SLICES-1];
  kl_pkg::word_t         ebus_word;

  // Carry between slices. Entry k is the carry out of slice k, and the
  // extra entry at the low end is the constant 1 that makes an increment.
  // Carry out of slice 0 falls off, so the accumulator wraps at 2**36
  logic cry_chain [0:kl_pkg::EDP_SLICES];

  assign cry_chain[kl_pkg::EDP_SLICES] = 1'b1;

  // The front end is one more bus driver
  always_comb begin
    fe_drv.driving = fe_drive;
    fe_drv.data    = fe_data;
  end

  diag_ctl u_diag_ctl (
    .clk         (clk),
    .arst_n      (arst_n),
    .ds          (ds),
    .diag_strobe (diag_strobe),
    .cmd         (cmd)
  );

  scratch_board u_scratch_board (
    .clk       (clk),
    .arst_n    (arst_n),
    .cmd       (cmd),
    .ebus_word (ebus_word),
    .drv       (scr_drv)
  );

  for (genvar k = 0; k < kl_pkg::EDP_SLICES; k++) begin : g_edp
    edp_slice #(
      .SLICE (k)
    ) u_edp_slice (
      .clk       (clk),
      .arst_n    (arst_n),
      .cmd       (cmd),
      .ebus_word (ebus_word),
      .cry_in    (cry_chain[k+1]),
      .cry_out   (cry_chain[k]),
      .drv       (edp_drv[k])
    );
  end

  ebus_mux u_ebus_mux (
    .fe_drv      (fe_drv),
    .scr_drv     (scr_drv),
    .edp_drv     (edp_drv),
    .ebus_word   (ebus_word),
    .ebus_parity (ebus_parity)
  );

  assign ebus_data = ebus_word;

endmodule

// File: kl_ebus_sva.sv
`timescale 1ns/10ps

module kl_ebus_sva (
  input logic               clk,
  input logic               arst_n,
  input kl_pkg::diag_cmd_t  cmd,
  input logic               fe_drive,
  input kl_pkg::word_t      ebus_data,
  input logic               ebus_parity
);

  logic [3:0] wr_fields;
  logic       any_read;

  assign wr_fields = {cmd.scr0_wr, cmd.scr1_wr, cmd.edp_ld, cmd.edp_inc};
  assign any_read  = cmd.scr0_rd | cmd.scr1_rd | cmd.edp_rd;

  // Write and increment controls are single-cycle pulses
  a_wr_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    (wr_fields & $past(wr_fields)) == 4'b0000)
    else $error("write control high for two cycles");

  // An undriven bus reads zero
  a_idle_zero: assert property (@(posedge clk) disable iff (!arst_n)
    (!fe_drive && !any_read) |-> (ebus_data == '0))
    else $error("ebus_data not zero with no driver");

  a_odd_parity: assert property (@(posedge clk) disable iff (!arst_n)
    ^{ebus_data, ebus_parity})
    else $error("ebus parity is even");

  a_reset_quiet: assert property (@(posedge clk)
    $rose(arst_n) |-> ((cmd == '0) && (ebus_data == '0)))
    else $error("bus not quiet after reset");

endmodule

bind kl_ebus_top kl_ebus_sva u_kl_ebus_sva (
  .clk         (clk),
  .arst_n      (arst_n),
  .cmd         (cmd),
  .fe_drive    (fe_drive),
  .ebus_data   (ebus_data),
  .ebus_parity (ebus_parity)
);

// File: tb_kl_ebus.sv
`timescale 1ns/10ps

module tb_kl_ebus;

  logic              clk;
  logic              arst_n;
  kl_pkg::diag_fn_t  ds;
  logic              diag_strobe;
  logic              fe_drive;
  kl_pkg::word_t     fe_data;
  kl_pkg::word_t     ebus_data;
  logic              ebus_parity;

  // What the boards should hold after each command
  kl_pkg::word_t scr0_m;
  kl_pkg::word_t scr1_m;
  kl_pkg::word_t acc_m;

  // Sampled reads waiting for the compare process
  kl_pkg::word_t got_q [$];
  kl_pkg::word_t exp_q [$];
  logic          par_q [$];
  string         lbl_q [$];

  kl_pkg::word_t got;
  kl_pkg::word_t exp_w;
  logic          par;
  string         lbl;

  integer seed;
  int     checks;
  int     errors;
  int     par_errors;
  int     test_checks;
  int     test_errors;
  int     test_num;
  int     wait_n;

  kl_ebus_top UUT (
    .clk         (clk),
    .arst_n      (arst_n),
    .ds          (ds),
    .diag_strobe (diag_strobe),
    .fe_drive    (fe_drive),
    .fe_data     (fe_data),
    .ebus_data   (ebus_data),
    .ebus_parity (ebus_parity)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Reset is held for five cycles and let go on a falling edge
  initial begin
    arst_n = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

  function automatic kl_pkg::word_t rand_word();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return r[35:0];
  endfunction

  // Expected bus word for a read, from the front end or the mirrored boards
  function automatic kl_pkg::word_t ref_read(input kl_pkg::diag_fn_t fn,
                                             input logic drive,
                                             input kl_pkg::word_t data);
    kl_pkg::word_t w;
    w = '0;
    if (drive) begin
      w = data;
    end else if (fn == kl_pkg::FN_SCR0_RD) begin
      w = scr0_m;
    end else if (fn == kl_pkg::FN_SCR1_RD) begin
      w = scr1_m;
    end else if (fn == kl_pkg::FN_EDP_RD) begin
      w = acc_m;
    end
    return w;
  endfunction

  // Code 00 is not a diagnostic function, so the bus goes idle
  task automatic go_idle();
    ds       = 7'h00;
    fe_drive = 1'b0;
    fe_data  = '0;
  endtask

  task automatic do_write(input kl_pkg::diag_fn_t fn, input kl_pkg::word_t w);
    @(negedge clk);
    ds          = fn;
    fe_drive    = 1'b1;
    fe_data     = w;
    diag_strobe = 1'b1;
    @(negedge clk);
    diag_strobe = 1'b0;
    // The board takes the word on this edge
    @(posedge clk);
    @(negedge clk);
    go_idle();
    if (fn == kl_pkg::FN_SCR0_WR) begin
      scr0_m = w;
    end else if (fn == kl_pkg::FN_SCR1_WR) begin
      scr1_m = w;
    end else if (fn == kl_pkg::FN_EDP_LD) begin
      acc_m = w;
    end
  endtask

  task automatic do_inc();
    @(negedge clk);
    ds          = kl_pkg::FN_EDP_INC;
    diag_strobe = 1'b1;
    @(negedge clk);
    diag_strobe = 1'b0;
    @(posedge clk);
    @(negedge clk);
    go_idle();
    acc_m = acc_m + 36'd1;
  endtask

  task automatic do_read(input kl_pkg::diag_fn_t fn, input logic drive,
                         input kl_pkg::word_t data, input string label);
    @(negedge clk);
    ds       = fn;
    fe_drive = drive;
    fe_data  = data;
    repeat (2) @(posedge clk);
    @(negedge clk);
    got_q.push_back(ebus_data);
    par_q.push_back(ebus_parity);
    exp_q.push_back(ref_read(fn, drive, data));
    lbl_q.push_back(label);
    go_idle();
  endtask

  // Compare every sampled read against the model and the parity rule
  always @(negedge clk) begin
    while (got_q.size() > 0) begin
      got   = got_q.pop_front();
      exp_w = exp_q.pop_front();
      par   = par_q.pop_front();
      lbl   = lbl_q.pop_front();
      checks++;
      if (got !== exp_w) begin
        errors++;
        $display("** Error at %0t: ebus_data = %h, expected %h (%s)", $time, got, exp_w, lbl);
      end
      if ((^{got, par}) !== 1'b1) begin
        errors++;
        par_errors++;
        $display("** Error at %0t: ebus_parity = %b, expected %b (%s)",
                 $time, par, ~par, lbl);
      end
    end
  end

  task automatic end_test(input string name);
    int n_chk;
    int n_err;
    // Two falling edges give the compare process time to drain
    repeat (2) @(negedge clk);
    n_chk = checks - test_checks;
    n_err = errors - test_errors;
    test_num++;
    if (n_err == 0) begin
      $display("Test %0d %s: ok, %0d reads checked", test_num, name, n_chk);
    end else begin
      $display("Test %0d %s: %0d errors in %0d reads", test_num, name, n_err, n_chk);
    end
    test_checks = checks;
    test_errors = errors;
  endtask

  task automatic run_tests();
    int            i;
    kl_pkg::word_t w0;
    kl_pkg::word_t w1;
    kl_pkg::word_t inc_vec [0:4];

    do_read(7'h00, 1'b0, '0, "idle bus");
    do_read(kl_pkg::FN_SCR0_RD, 1'b0, '0, "scr0 after reset");
    do_read(kl_pkg::FN_SCR1_RD, 1'b0, '0, "scr1 after reset");
    do_read(kl_pkg::FN_EDP_RD, 1'b0, '0, "edp after reset");
    end_test("reset state");

    for (i = 0; i < 4; i++) begin
      w0 = rand_word();
      w1 = rand_word();
      do_write(kl_pkg::FN_SCR0_WR, w0);
      do_write(kl_pkg::FN_SCR1_WR, w1);
      do_read(kl_pkg::FN_SCR0_RD, 1'b0, '0, "scr0 readback");
      do_read(kl_pkg::FN_SCR1_RD, 1'b0, '0, "scr1 readback");
    end
    end_test("scratch registers");

    for (i = 0; i < 4; i++) begin
      do_write(kl_pkg::FN_EDP_LD, rand_word());
      do_read(kl_pkg::FN_EDP_RD, 1'b0, '0, "edp readback");
    end
    end_test("edp load and read");

    // All ones wraps, low field 63 carries once, low 30 ones carry all the way
    inc_vec[0] = 36'hFFFFFFFFF;
    inc_vec[1] = 36'h12345603F;
    inc_vec[2] = 36'h57FFFFFFF;
    inc_vec[3] = rand_word();
    inc_vec[4] = rand_word();
    for (i = 0; i < 5; i++) begin
      do_write(kl_pkg::FN_EDP_LD, inc_vec[i]);
      do_inc();
      do_read(kl_pkg::FN_EDP_RD, 1'b0, '0, "edp increment");
    end
    do_inc();
    do_read(kl_pkg::FN_EDP_RD, 1'b0, '0, "edp second increment");
    end_test("edp increment");

    w0 = rand_word();
    w1 = rand_word();
    do_write(kl_pkg::FN_SCR0_WR, w0);
    do_read(kl_pkg::FN_SCR0_RD, 1'b1, w1, "front end over scratch");
    do_read(kl_pkg::FN_SCR0_RD, 1'b0, '0, "scratch after release");
    w0 = rand_word();
    w1 = rand_word();
    do_write(kl_pkg::FN_EDP_LD, w0);
    do_read(kl_pkg::FN_EDP_RD, 1'b1, w1, "front end over edp");
    do_read(kl_pkg::FN_EDP_RD, 1'b0, '0, "edp after release");
    end_test("bus priority");

    do_read(7'h00, 1'b1, '1, "parity all ones");
    do_read(7'h00, 1'b1, 36'h000000001, "parity single one");
    for (i = 0; i < 6; i++) begin
      do_read(7'h00, 1'b1, rand_word(), "parity random word");
    end
    end_test("parity");
  endtask

  initial begin
    seed        = 23;
    checks      = 0;
    errors      = 0;
    par_errors  = 0;
    test_checks = 0;
    test_errors = 0;
    test_num    = 0;
    diag_strobe = 1'b0;
    scr0_m      = '0;
    scr1_m      = '0;
    acc_m       = '0;
    go_idle();

    wait_n = 0;
    while ((arst_n !== 1'b1) && (wait_n < 20)) begin
      @(negedge clk);
      wait_n++;
    end

    if (arst_n !== 1'b1) begin
      $display("Timeout: reset was never released");
      $display("Simulation finished: FAIL");
      $finish;
    end else begin
      run_tests();
      $display("Reads checked: %0d, errors: %0d, parity errors: %0d",
               checks, errors, par_errors);
      if (errors == 0) begin
        $display("Simulation finished: PASS");
      end else begin
        $display("Simulation finished: FAIL");
      end
      $finish;
    end
  end

endmodule

// File: src.f
kl_pkg.sv
diag_ctl.sv
scratch_board.sv
edp_slice.sv
ebus_mux.sv
kl_ebus_top.sv
kl_ebus_sva.sv
tb_kl_ebus.sv

// File: run.sh
#!/bin/sh
# Build the EBUS testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_kl_ebus \
  --Mdir obj_dir -o sim_kl_ebus -f src.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/sim_kl_ebus > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
  echo "Run failed, see $LOG"
  exit 1
fi

echo "Run passed"
exit 0
